// File: sources.f
+incdir+include
rtl/lsu_pkg.sv
rtl/lsu_pipe_reg.sv
rtl/lsu_agu.sv
rtl/lsu_req_buffer.sv
rtl/lsu_misalign_check.sv
rtl/lsu_access_stage.sv
rtl/lsu_top.sv
verification/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module lsu_tb \
    --Mdir obj_dir -o lsu_tb_sim > build.log 2>&1 \
    && ./obj_dir/lsu_tb_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "SOME TESTS FAILED" sim.log \
    && { echo "simulation reported failures"; exit 1; } \
    || echo "simulation finished without failures"

// File: include/lsu_tb_model.svh
// --------------------------------------
// reference model for the lsu testbench
// shadow data memory and expected results
// --------------------------------------
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

    // mirror of the data RAM, doubleword wide
    logic [XLEN-1:0] shadow_mem [RAM_WORDS];

    function automatic int unsigned access_bytes(input lsu_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    // expected result of one request, stores also update the shadow memory
    function automatic lsu_result_t expect_result(input fu_data_t req, input logic en_tr);
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] val;
        int unsigned     nbytes;
        int unsigned     ofs;
        logic            is_store;
        logic            is_signed;
        lsu_result_t     res;
        addr         = req.operand_a + req.imm;
        nbytes       = access_bytes(req.operation);
        ofs          = 32'(addr[2:0]);
        is_store     = req.operation inside {SB, SH, SW, SD};
        is_signed    = req.operation inside {LB, LH, LW};
        res          = '0;
        res.valid    = 1'b1;
        res.trans_id = req.trans_id;
        // sv39 wants bits 63 down to 38 to agree
        if (en_tr && addr[63:38] != '0 && addr[63:38] != '1) begin
            res.ex.valid = 1'b1;
            res.ex.cause = is_store ? CAUSE_ST_ACCESS : CAUSE_LD_ACCESS;
            res.ex.tval  = addr & 64'h0000_007f_ffff_ffff;
        end else if (ofs % nbytes != 0) begin
            res.ex.valid = 1'b1;
            res.ex.cause = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
            res.ex.tval  = addr & 64'h0000_007f_ffff_ffff;
        end else if (is_store) begin
            for (int unsigned i = 0; i < nbytes; i++) begin
                shadow_mem[addr[10:3]][(ofs + i) * 8 +: 8] = req.operand_b[i * 8 +: 8];
            end
        end else begin
            word = shadow_mem[addr[10:3]] >> (ofs * 8);
            val  = '0;
            for (int unsigned i = 0; i < nbytes; i++) begin
                val[i * 8 +: 8] = word[i * 8 +: 8];
            end
            if (is_signed && val[nbytes * 8 - 1]) begin
                val = val | (~64'h0 << (nbytes * 8));
            end
            res.result = val;
        end
        return res;
    endfunction

`endif

// File: verification/lsu_tb.sv
// --------------------------------------
// load/store unit testbench
// directed and random requests, result
// comparison, flush check, run limit
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    localparam int unsigned LATENCY    = 3;
    localparam int unsigned NUM_RAND   = 200;
    // directed requests per test plus the random burst
    localparam int unsigned NUM_REQ    = 32 + 8 + 4 + 5 + NUM_RAND;
    localparam int unsigned MAX_CYCLES = NUM_REQ + 50;

    typedef struct packed {
        int unsigned due;
        lsu_result_t res;
    } expect_t;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        flush_i;
    logic        en_tr;
    logic        lsu_valid_i;
    fu_data_t    fu_data_i;
    logic        lsu_ready_o;
    lsu_result_t load_o;
    lsu_result_t store_o;

    expect_t                  ld_exp_q [$];
    expect_t                  st_exp_q [$];
    int unsigned              cycle        = 0;
    int unsigned              mismatch_cnt = 0;
    int unsigned              other_cnt    = 0;
    logic [TRANS_ID_BITS-1:0] next_id      = '0;
    integer                   seed         = 32'h01d08cfb;

    lsu_op_e         store_ops [4] = '{SD, SW, SH, SB};
    lsu_op_e         load_ops  [7] = '{LB, LBU, LH, LHU, LW, LWU, LD};
    logic [XLEN-1:0] size_ofs  [4] = '{64'd0, 64'd12, 64'd22, 64'd31};

    `include "lsu_tb_model.svh"

    lsu_top lsu_top_i (
        .clk_i                  ( clk_i       ),
        .rst_ni                 ( rst_ni      ),
        .flush_i                ( flush_i     ),
        .en_ld_st_translation_i ( en_tr       ),
        .lsu_valid_i            ( lsu_valid_i ),
        .fu_data_i              ( fu_data_i   ),
        .lsu_ready_o            ( lsu_ready_o ),
        .load_o                 ( load_o      ),
        .store_o                ( store_o     )
    );

    always #2 clk_i = ~clk_i;

    // edge counter and run limit
    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle == MAX_CYCLES) begin
            $display("error: run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_load(input lsu_result_t got, input lsu_result_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: load result %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_store(input lsu_result_t got, input lsu_result_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: store result %h, expected %h", $time, got, exp);
        end
    endtask

    // ----------------------------------------
    // result comparison at mid cycle
    // ----------------------------------------
    always @(negedge clk_i) begin
        if (ld_exp_q.size() != 0 && ld_exp_q[0].due == cycle + 1) begin
            if (load_o.valid) begin
                check_load(load_o, ld_exp_q[0].res);
            end else begin
                other_cnt++;
                $display("error at %0t: load result for id %0d did not arrive",
                         $time, ld_exp_q[0].res.trans_id);
            end
            void'(ld_exp_q.pop_front());
        end else if (load_o.valid) begin
            other_cnt++;
            $display("error at %0t: unexpected load result, id %0d", $time, load_o.trans_id);
        end
        if (st_exp_q.size() != 0 && st_exp_q[0].due == cycle + 1) begin
            if (store_o.valid) begin
                check_store(store_o, st_exp_q[0].res);
            end else begin
                other_cnt++;
                $display("error at %0t: store result for id %0d did not arrive",
                         $time, st_exp_q[0].res.trans_id);
            end
            void'(st_exp_q.pop_front());
        end else if (store_o.valid) begin
            other_cnt++;
            $display("error at %0t: unexpected store result, id %0d", $time, store_o.trans_id);
        end
    end

    // drives one request for one cycle and queues its expected result
    task automatic send_req(input lsu_op_e op, input logic [XLEN-1:0] base,
                            input logic [XLEN-1:0] imm, input logic [XLEN-1:0] data);
        fu_data_t req;
        expect_t  e;
        req.operation = op;
        req.operand_a = base;
        req.operand_b = data;
        req.imm       = imm;
        req.trans_id  = next_id;
        next_id       = next_id + 1'b1;
        if (!lsu_ready_o) begin
            other_cnt++;
            $display("error at %0t: lsu_ready_o is low when a request is offered", $time);
        end
        fu_data_i   = req;
        lsu_valid_i = 1'b1;
        e.due       = cycle + 1 + LATENCY;
        e.res       = expect_result(req, en_tr);
        if (op inside {SB, SH, SW, SD}) begin
            st_exp_q.push_back(e);
        end else begin
            ld_exp_q.push_back(e);
        end
        @(posedge clk_i);
        #1;
        lsu_valid_i = 1'b0;
    endtask

    task automatic wait_drained();
        while (ld_exp_q.size() != 0 || st_exp_q.size() != 0) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // results due after the flush edge never show up
    task automatic flush_pulse();
        int unsigned flush_edge;
        flush_edge = cycle + 1;
        flush_i    = 1'b1;
        while (ld_exp_q.size() != 0 && ld_exp_q[$].due > flush_edge) begin
            void'(ld_exp_q.pop_back());
        end
        while (st_exp_q.size() != 0 && st_exp_q[$].due > flush_edge) begin
            void'(st_exp_q.pop_back());
        end
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
    endtask

    task automatic random_burst(input int unsigned count);
        logic [31:0]     r_addr;
        logic [31:0]     r_hi;
        logic [31:0]     r_lo;
        logic [31:0]     r_op;
        logic [XLEN-1:0] base;
        for (int unsigned n = 0; n < count; n++) begin
            r_addr = $random(seed);
            r_hi   = $random(seed);
            r_lo   = $random(seed);
            r_op   = $random(seed);
            base   = {53'h0, r_addr[10:0]};
            // now and then an address outside sv39
            if (r_addr[15:12] == 4'h0) begin
                base[45] = 1'b1;
            end
            en_tr = (r_addr[17:16] != 2'b00);
            send_req(lsu_op_e'(4'(r_op % 32'd11)), base, {61'h0, r_addr[20:18]}, {r_hi, r_lo});
        end
    endtask

    initial begin
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        en_tr       = 1'b1;
        lsu_valid_i = 1'b0;
        fu_data_i   = '0;
        foreach (shadow_mem[i]) begin
            shadow_mem[i] = '0;
        end
        repeat (5) @(posedge clk_i);
        #1;
        if (lsu_ready_o !== 1'b0) begin
            other_cnt++;
            $display("error at %0t: lsu_ready_o is high during reset", $time);
        end
        rst_ni = 1'b1;
        @(posedge clk_i);
        #1;

        // each store size, then every load kind from its address
        for (int s = 0; s < 4; s++) begin
            send_req(store_ops[s], 64'h100, size_ofs[s], 64'hf0e1_d2c3_b4a5_9687);
            for (int l = 0; l < 7; l++) begin
                send_req(load_ops[l], 64'h100, size_ofs[s], 64'h0);
            end
        end
        wait_drained();

        // misaligned accesses, then check memory is untouched
        send_req(SH, 64'h200, 64'd1, 64'h1111_2222_3333_4444);
        send_req(SW, 64'h200, 64'd2, 64'h5555_6666_7777_8888);
        send_req(SD, 64'h200, 64'd4, 64'h9999_aaaa_bbbb_cccc);
        send_req(LH, 64'h200, 64'd3, 64'h0);
        send_req(LW, 64'h200, 64'd6, 64'h0);
        send_req(LD, 64'h200, 64'd12, 64'h0);
        send_req(LD, 64'h200, 64'd0, 64'h0);
        send_req(LD, 64'h200, 64'd8, 64'h0);
        wait_drained();

        // bit 38 set without sign extension
        send_req(SD, 64'h0000_0040_0000_0300, 64'd0, 64'h0123_4567_89ab_cdef);
        send_req(LD, 64'h0000_0040_0000_0300, 64'd0, 64'h0);
        en_tr = 1'b0;
        send_req(SD, 64'h0000_0040_0000_0300, 64'd0, 64'h0123_4567_89ab_cdef);
        send_req(LD, 64'h0000_0040_0000_0300, 64'd0, 64'h0);
        wait_drained();

        random_burst(NUM_RAND);
        wait_drained();

        // two loads in flight, flush, then normal traffic
        en_tr = 1'b1;
        send_req(LD, 64'h100, 64'd0, 64'h0);
        send_req(LW, 64'h100, 64'd4, 64'h0);
        flush_pulse();
        send_req(SD, 64'h380, 64'd0, 64'hdead_beef_0bad_f00d);
        send_req(LD, 64'h380, 64'd0, 64'h0);
        send_req(LW, 64'h380, 64'd4, 64'h0);
        wait_drained();

        // a few idle cycles to catch stray results
        repeat (4) @(posedge clk_i);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/lsu_top.sv
// --------------------------------------
// load/store unit top level
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 en_ld_st_translation_i,
    input  logic                 lsu_valid_i,
    input  lsu_pkg::fu_data_t    fu_data_i,
    output logic                 lsu_ready_o,
    output lsu_pkg::lsu_result_t load_o,
    output lsu_pkg::lsu_result_t store_o
);
    import lsu_pkg::*;

    lsu_ctrl_t   agu_req;
    lsu_ctrl_t   head;
    exception_t  head_ex;
    logic        pop;
    lsu_result_t ld_res;
    lsu_result_t st_res;

    lsu_agu i_agu (
        .fu_data_i        ( fu_data_i              ),
        .valid_i          ( lsu_valid_i            ),
        .en_translation_i ( en_ld_st_translation_i ),
        .req_o            ( agu_req                )
    );

    lsu_req_buffer i_req_buffer (
        .clk_i   ( clk_i       ),
        .rst_ni  ( rst_ni      ),
        .flush_i ( flush_i     ),
        .req_i   ( agu_req     ),
        .pop_i   ( pop         ),
        .ctrl_o  ( head        ),
        .ready_o ( lsu_ready_o )
    );

    lsu_misalign_check i_misalign_check (
        .ctrl_i ( head    ),
        .ex_o   ( head_ex )
    );

    lsu_access_stage i_access_stage (
        .clk_i   ( clk_i   ),
        .rst_ni  ( rst_ni  ),
        .flush_i ( flush_i ),
        .ctrl_i  ( head    ),
        .ex_i    ( head_ex ),
        .pop_o   ( pop     ),
        .load_o  ( ld_res  ),
        .store_o ( st_res  )
    );

    // output register stages
    lsu_pipe_reg #(
        .Depth ( LOAD_PIPE_DEPTH ),
        .T     ( lsu_result_t    )
    ) i_pipe_reg_load (
        .clk_i  ( clk_i  ),
        .rst_ni ( rst_ni ),
        .d_i    ( ld_res ),
        .d_o    ( load_o )
    );

    lsu_pipe_reg #(
        .Depth ( STORE_PIPE_DEPTH ),
        .T     ( lsu_result_t     )
    ) i_pipe_reg_store (
        .clk_i  ( clk_i   ),
        .rst_ni ( rst_ni  ),
        .d_i    ( st_res  ),
        .d_o    ( store_o )
    );

endmodule

`default_nettype wire

// File: rtl/lsu_access_stage.sv
// --------------------------------------
// translation register, data RAM,
// load data extraction, result registers
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

module lsu_access_stage (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  lsu_pkg::lsu_ctrl_t   ctrl_i,
    input  lsu_pkg::exception_t  ex_i,
    output logic                 pop_o,
    output lsu_pkg::lsu_result_t load_o,
    output lsu_pkg::lsu_result_t store_o
);
    import lsu_pkg::*;

    lsu_ctrl_t            ctrl_q;
    exception_t           ex_q;
    logic [VLEN-1:0]      paddr;
    logic [RAM_IDX_W-1:0] idx;
    logic [XLEN-1:0]      mem_q [RAM_WORDS];
    logic [XLEN-1:0]      rdata_shift;
    logic [XLEN-1:0]      wdata_shift;
    logic [XLEN-1:0]      ld_data;
    logic                 do_access;
    lsu_result_t          result_d;
    lsu_result_t          load_q;
    lsu_result_t          store_q;

    // head is taken whenever it is valid
    assign pop_o = ctrl_i.valid;

    // --------------------------------------
    // translation stage without an MMU
    // --------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ctrl_q <= '0;
            ex_q   <= '0;
        end else begin
            ctrl_q <= ctrl_i;
            ex_q   <= ex_i;
            if (flush_i) begin
                ctrl_q.valid <= 1'b0;
            end
        end
    end

    // physical equals virtual
    assign paddr     = ctrl_q.vaddr;
    assign idx       = paddr[RAM_IDX_W+2:3];
    assign do_access = ctrl_q.valid && !ex_q.valid && !flush_i;

    // --------------------------------------
    // data RAM
    // --------------------------------------
    assign wdata_shift = ctrl_q.wdata << {paddr[2:0], 3'b000};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (do_access && ctrl_q.fu == FU_STORE) begin
            for (int b = 0; b < BE_W; b++) begin
                if (ctrl_q.be[b]) begin
                    mem_q[idx][b*8 +: 8] <= wdata_shift[b*8 +: 8];
                end
            end
        end
    end

    // byte select and sign or zero extension
    assign rdata_shift = mem_q[idx] >> {paddr[2:0], 3'b000};

    always_comb begin
        case (ctrl_q.operation)
            LB:      ld_data = {{(XLEN-8){rdata_shift[7]}}, rdata_shift[7:0]};
            LBU:     ld_data = {{(XLEN-8){1'b0}}, rdata_shift[7:0]};
            LH:      ld_data = {{(XLEN-16){rdata_shift[15]}}, rdata_shift[15:0]};
            LHU:     ld_data = {{(XLEN-16){1'b0}}, rdata_shift[15:0]};
            LW:      ld_data = {{(XLEN-32){rdata_shift[31]}}, rdata_shift[31:0]};
            LWU:     ld_data = {{(XLEN-32){1'b0}}, rdata_shift[31:0]};
            default: ld_data = rdata_shift;
        endcase
    end

    // --------------------------------------
    // result registers
    // --------------------------------------
    always_comb begin
        result_d.valid    = ctrl_q.valid && !flush_i;
        result_d.trans_id = ctrl_q.trans_id;
        result_d.ex       = ex_q;
        // stores and excepted ops report zero
        result_d.result   = (do_access && ctrl_q.fu == FU_LOAD) ? ld_data : '0;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            load_q  <= '0;
            store_q <= '0;
        end else begin
            load_q        <= result_d;
            store_q       <= result_d;
            load_q.valid  <= result_d.valid && (ctrl_q.fu == FU_LOAD);
            // store side decoded from the operation itself
            store_q.valid <= result_d.valid && (ctrl_q.operation inside {SB, SH, SW, SD});
        end
    end

    // a flush also kills the results about to enter the pipe registers
    always_comb begin
        load_o        = load_q;
        load_o.valid  = load_q.valid && !flush_i;
        store_o       = store_q;
        store_o.valid = store_q.valid && !flush_i;
    end

    // fires when the fu field disagrees with the operation
    a_one_result : assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0({load_q.valid, store_q.valid})
    );

endmodule

`default_nettype wire

// File: rtl/lsu_misalign_check.sv
// --------------------------------------
// misaligned and access fault detection
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

module lsu_misalign_check (
    input  lsu_pkg::lsu_ctrl_t  ctrl_i,
    output lsu_pkg::exception_t ex_o
);
    import lsu_pkg::*;

    logic misaligned;
    logic is_store;

    assign is_store = (ctrl_i.fu == FU_STORE);

    always_comb begin
        case (op_size(ctrl_i.operation))
            2'd1:    misaligned = ctrl_i.vaddr[0];
            2'd2:    misaligned = |ctrl_i.vaddr[1:0];
            2'd3:    misaligned = |ctrl_i.vaddr[2:0];
            // bytes are always aligned
            default: misaligned = 1'b0;
        endcase
    end

    always_comb begin
        ex_o.valid = 1'b0;
        ex_o.cause = '0;
        ex_o.tval  = '0;
        if (ctrl_i.valid) begin
            if (ctrl_i.overflow) begin
                // access fault wins over misalignment
                ex_o.valid = 1'b1;
                ex_o.cause = is_store ? CAUSE_ST_ACCESS : CAUSE_LD_ACCESS;
                ex_o.tval  = {{(XLEN-VLEN){1'b0}}, ctrl_i.vaddr};
            end else if (misaligned) begin
                ex_o.valid = 1'b1;
                ex_o.cause = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
                ex_o.tval  = {{(XLEN-VLEN){1'b0}}, ctrl_i.vaddr};
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/lsu_req_buffer.sv
// --------------------------------------
// two-entry request buffer
// presents the incoming request when empty
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

module lsu_req_buffer (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  lsu_pkg::lsu_ctrl_t req_i,
    input  logic               pop_i,
    output lsu_pkg::lsu_ctrl_t ctrl_o,
    output logic               ready_o
);
    import lsu_pkg::*;

    lsu_ctrl_t  mem_q [2];
    logic       rd_ptr_q, rd_ptr_d;
    logic       wr_ptr_q, wr_ptr_d;
    logic [1:0] count_q, count_d;
    logic       ready_q;
    logic       empty;
    logic       push;
    logic       deq;

    assign empty = (count_q == 2'd0);
    // an empty buffer hands the request straight through
    assign ctrl_o  = empty ? req_i : mem_q[rd_ptr_q];
    assign ready_o = ready_q;

    assign push = req_i.valid && !(empty && pop_i) && !flush_i;
    assign deq  = pop_i && !empty;

    always_comb begin
        rd_ptr_d = rd_ptr_q ^ deq;
        wr_ptr_d = wr_ptr_q ^ push;
        count_d  = count_q + {1'b0, push} - {1'b0, deq};
        if (flush_i) begin
            rd_ptr_d = 1'b0;
            wr_ptr_d = 1'b0;
            count_d  = 2'd0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            count_q  <= 2'd0;
            ready_q  <= 1'b0;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            count_q  <= count_d;
            ready_q  <= (count_d != 2'd2);
        end
    end

    // entries only, occupancy lives in count_q
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    a_no_push_full : assert property (
        @(posedge clk_i) disable iff (!rst_ni) push |-> (count_q != 2'd2)
    );

    // the access stage only pops a valid head
    a_no_pop_empty : assert property (
        @(posedge clk_i) disable iff (!rst_ni) pop_i |-> (!empty || req_i.valid)
    );

endmodule

`default_nettype wire

// File: rtl/lsu_agu.sv
// --------------------------------------
// address generation unit
// vaddr, sv39 overflow flag, byte enables
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

module lsu_agu (
    input  lsu_pkg::fu_data_t  fu_data_i,
    input  logic               valid_i,
    input  logic               en_translation_i,
    output lsu_pkg::lsu_ctrl_t req_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0]      vaddr_xlen;
    logic [XLEN-SV_BITS-1:0] upper;
    logic                 overflow;
    logic [BE_W-1:0]      be;

    // base plus immediate, full width before truncation
    assign vaddr_xlen = fu_data_i.operand_a + fu_data_i.imm;
    assign upper      = vaddr_xlen[XLEN-1:SV_BITS];

    // upper bits must be all ones or all zeros
    assign overflow = en_translation_i && !((&upper) || !(|upper));

    // byte enables from size and low address bits
    always_comb begin
        case (op_size(fu_data_i.operation))
            2'd0:    be = BE_W'(8'h01) << vaddr_xlen[2:0];
            2'd1:    be = BE_W'(8'h03) << vaddr_xlen[2:0];
            2'd2:    be = BE_W'(8'h0f) << vaddr_xlen[2:0];
            default: be = '1;
        endcase
    end

    always_comb begin
        req_o.valid     = valid_i;
        req_o.vaddr     = vaddr_xlen[VLEN-1:0];
        req_o.overflow  = overflow;
        req_o.wdata     = fu_data_i.operand_b;
        req_o.be        = be;
        req_o.operation = fu_data_i.operation;
        req_o.trans_id  = fu_data_i.trans_id;
        case (fu_data_i.operation)
            SB, SH, SW, SD: req_o.fu = FU_STORE;
            default:        req_o.fu = FU_LOAD;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/lsu_pipe_reg.sv
// --------------------------------------
// result shift register, any payload type
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

module lsu_pipe_reg #(
    parameter int unsigned Depth = 1,
    parameter type         T     = logic
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  T     d_i,
    output T     d_o
);

    if (Depth == 0) begin : gen_pass
        assign d_o = d_i;
    end else begin : gen_shift
        T stage_q [Depth];

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                for (int unsigned i = 0; i < Depth; i++) begin
                    stage_q[i] <= '0;
                end
            end else begin
                stage_q[0] <= d_i;
                for (int unsigned i = 1; i < Depth; i++) begin
                    stage_q[i] <= stage_q[i-1];
                end
            end
        end

        assign d_o = stage_q[Depth-1];
    end

endmodule

`default_nettype wire

// File: rtl/lsu_pkg.sv
// --------------------------------------
// load/store unit package
// widths, operation encoding, cause codes
// request, result and exception structs
// --------------------------------------
`default_nettype none

package lsu_pkg;

    // --------------------------------------
    // widths and sizes
    // --------------------------------------
    localparam int unsigned XLEN             = 64;
    localparam int unsigned VLEN             = 39;
    // first bit that has to match the sign in sv39
    localparam int unsigned SV_BITS          = 38;
    localparam int unsigned BE_W             = XLEN / 8;
    localparam int unsigned TRANS_ID_BITS    = 3;
    localparam int unsigned RAM_WORDS        = 256;
    localparam int unsigned RAM_IDX_W        = 8;
    localparam int unsigned LOAD_PIPE_DEPTH  = 1;
    localparam int unsigned STORE_PIPE_DEPTH = 1;

    // --------------------------------------
    // encodings
    // --------------------------------------
    typedef enum logic [3:0] {
        LB, LBU, LH, LHU, LW, LWU, LD,
        SB, SH, SW, SD
    } lsu_op_e;

    typedef enum logic {
        FU_LOAD,
        FU_STORE
    } fu_e;

    localparam logic [5:0] CAUSE_LD_MISALIGNED = 6'd4;
    localparam logic [5:0] CAUSE_LD_ACCESS     = 6'd5;
    localparam logic [5:0] CAUSE_ST_MISALIGNED = 6'd6;
    localparam logic [5:0] CAUSE_ST_ACCESS     = 6'd7;

    // --------------------------------------
    // structs
    // --------------------------------------
    typedef struct packed {
        logic            valid;
        logic [5:0]      cause;
        logic [XLEN-1:0] tval;
    } exception_t;

    typedef struct packed {
        lsu_op_e                  operation;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [XLEN-1:0]          imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    typedef struct packed {
        logic                     valid;
        logic [VLEN-1:0]          vaddr;
        logic                     overflow;
        logic [XLEN-1:0]          wdata;
        logic [BE_W-1:0]          be;
        fu_e                      fu;
        lsu_op_e                  operation;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } lsu_ctrl_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
        exception_t               ex;
    } lsu_result_t;

    // access size as log2 of the byte count
    function automatic logic [1:0] op_size(lsu_op_e op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            LW, LWU, SW: return 2'd2;
            default:     return 2'd3;
        endcase
    endfunction

endpackage

`default_nettype wire
